// File: sim.f
logic/fire_cmd_pkg.sv
logic/fire_drive_pkg.sv
logic/fire_sequencer.sv
logic/fire_timer.sv
logic/channel_ledger.sv
logic/decoder_drive.sv
logic/ignition_ctrl_top.sv
testbench/ignition_checker.sv
testbench/ignition_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = ignition_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/ignition_tb.sv
// ignition controller testbench: table driven fire commands with a firing monitor
`timescale 1ns/10ps

module ignition_tb;

	localparam int GUARD_CYCLES       = 12;
	localparam int DWELL_CYCLES       = 30;
	localparam int ACK_TIMEOUT_CYCLES = 8;
	localparam int NUM_ROWS           = 10;
	localparam int FIXED_ROWS         = 7;                        // rest are random
	localparam int ROW_BOUND          = 20 * (GUARD_CYCLES + DWELL_CYCLES + 4);
	localparam int RUN_LIMIT          = NUM_ROWS * ROW_BOUND;

	localparam fire_cmd_pkg::cmd_type_t   CMD_FIRE   = 8'h05;
	localparam fire_cmd_pkg::cmd_type_t   CMD_OTHER  = 8'h03;     // any non-fire code
	localparam fire_drive_pkg::chan_idx_t FIRST_HIGH = 5'd16;     // first 2-to-4 channel

	// nothing selected and bus unpowered
	localparam fire_drive_pkg::decoder_drive_t IDLE_EXP = '{
		low_code:   4'h0,
		low_strobe: 1'b0,
		low_en_n:   1'b1,
		high_code:  2'h0,
		high_en_n:  1'b1,
		pwr_on:     1'b0
	};

	typedef struct packed {
		fire_cmd_pkg::cmd_type_t  cmd_type;
		fire_cmd_pkg::chan_mask_t mask;
		logic                     ack_never;                      // pwr_ack held high
		logic                     inject;                         // second cmd mid-firing
		fire_cmd_pkg::chan_mask_t exp_status;
		fire_cmd_pkg::err_count_t exp_err_inc;
	} test_row_t;

	logic                           clk       = 1'b0;
	logic                           rst_n     = 1'b0;
	logic                           cmd_valid = 1'b0;
	fire_cmd_pkg::fire_cmd_t        cmd       = '0;
	logic                           pwr_ack   = 1'b1;
	fire_drive_pkg::decoder_drive_t drive_main;
	fire_drive_pkg::decoder_drive_t drive_backup;
	fire_cmd_pkg::chan_mask_t       status;
	fire_cmd_pkg::err_count_t       err_count;

	test_row_t                 rows [NUM_ROWS];
	string                     row_name [NUM_ROWS];
	fire_drive_pkg::chan_idx_t exp_order [$];                     // ascending mask bits
	string                     cur_row_name = "reset";
	logic                      cur_ack_low  = 1'b0;
	logic                      mon_on       = 1'b0;
	logic                      pwr_was_on   = 1'b0;
	int                        fire_total   = 0;                  // firings seen so far
	int                        fire_base    = 0;                  // fire_total at row start
	int                        cycle_cnt    = 0;
	integer                    seed         = 32'h3367;
	fire_drive_pkg::chan_idx_t cur_exp      = '0;
	fire_drive_pkg::chan_idx_t seen_chan    = '0;
	fire_cmd_pkg::chan_mask_t  model_status = '0;                 // status after last row
	fire_cmd_pkg::err_count_t  model_err    = '0;                 // errors due so far

	always #4 clk = ~clk;                                         // 8 ns period

	ignition_ctrl_top #(
		.GUARD_CYCLES       (GUARD_CYCLES),
		.DWELL_CYCLES       (DWELL_CYCLES),
		.ACK_TIMEOUT_CYCLES (ACK_TIMEOUT_CYCLES)
	) dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.cmd_valid    (cmd_valid),
		.cmd          (cmd),
		.pwr_ack      (pwr_ack),
		.drive_main   (drive_main),
		.drive_backup (drive_backup),
		.status       (status),
		.err_count    (err_count)
	);

	// --------------------
	// reporting
	// --------------------
	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_mask(input string name, input fire_cmd_pkg::chan_mask_t exp,
		input fire_cmd_pkg::chan_mask_t act);
		if (act !== exp) begin
			report_failure($sformatf("FAIL %s status expected %05h actual %05h", name, exp, act));
		end
	endtask

	task automatic check_chan(input string name, input fire_drive_pkg::chan_idx_t exp,
		input fire_drive_pkg::chan_idx_t act);
		if (act !== exp) begin
			report_failure($sformatf("FAIL %s channel expected %0d actual %0d", name, exp, act));
		end
	endtask

	task automatic check_err(input string name, input fire_cmd_pkg::err_count_t exp,
		input fire_cmd_pkg::err_count_t act);
		if (act !== exp) begin
			report_failure($sformatf("FAIL %s err_count expected %0d actual %0d", name, exp, act));
		end
	endtask

	task automatic check_drive(input string name, input fire_drive_pkg::decoder_drive_t exp,
		input fire_drive_pkg::decoder_drive_t act);
		if (act !== exp) begin
			report_failure($sformatf("FAIL %s drive expected %b actual %b", name, exp, act));
		end
	endtask

	// expected drive word while a channel fires
	function automatic fire_drive_pkg::decoder_drive_t fire_drive_exp(
		input fire_drive_pkg::chan_idx_t ch, input logic ack_low);
		fire_drive_pkg::decoder_drive_t d;
		d        = IDLE_EXP;
		d.pwr_on = 1'b1;
		if (ch < FIRST_HIGH) begin
			d.low_code   = ch[3:0];
			d.low_en_n   = 1'b0;
			d.low_strobe = ack_low;
		end else begin
			d.high_code = ch[1:0];                                // 16..19 map to 0..3
			d.high_en_n = !ack_low;
		end
		return d;
	endfunction

	// --------------------
	// stimulus table
	// --------------------
	task automatic set_row(input int i, input string name, input fire_cmd_pkg::cmd_type_t t,
		input fire_cmd_pkg::chan_mask_t m, input logic never, input logic inj,
		input fire_cmd_pkg::chan_mask_t st, input fire_cmd_pkg::err_count_t inc);
		row_name[i] = name;
		rows[i]     = '{t, m, never, inj, st, inc};
	endtask

	task automatic fill_table();
		fire_cmd_pkg::chan_mask_t prev;
		logic [31:0]              rnd;
		set_row(0, "both_banks",    CMD_FIRE,  20'h80025, 1'b0, 1'b0, 20'h80025, 8'd0);
		set_row(1, "no_ack",        CMD_FIRE,  20'h30102, 1'b1, 1'b0, 20'hB0127, 8'd4);
		set_row(2, "mid_fire_cmd",  CMD_FIRE,  20'h00C00, 1'b0, 1'b1, 20'hB0D27, 8'd0);
		set_row(3, "non_fire_type", CMD_OTHER, 20'hFFFFF, 1'b0, 1'b0, 20'hB0D27, 8'd0);
		set_row(4, "overlap",       CMD_FIRE,  20'h80021, 1'b0, 1'b0, 20'hB0D27, 8'd0);
		set_row(5, "zero_mask",     CMD_FIRE,  20'h00000, 1'b0, 1'b0, 20'hB0D27, 8'd0);
		set_row(6, "high_no_ack",   CMD_FIRE,  20'hF0000, 1'b1, 1'b0, 20'hF0D27, 8'd4);
		prev = rows[FIXED_ROWS-1].exp_status;
		for (int i = FIXED_ROWS; i < NUM_ROWS; i++) begin
			rnd = $random(seed);
			set_row(i, $sformatf("random_%0d", i - FIXED_ROWS), CMD_FIRE,
				rnd[19:0], rnd[20], 1'b0,
				(prev & ~rnd[19:0]) | rnd[19:0],                  // clear then refire
				rnd[20] ? fire_cmd_pkg::err_count_t'($countones(rnd[19:0])) : 8'd0);
			prev = rows[i].exp_status;
		end
	endtask

	// one-cycle command strobe from a falling edge
	task automatic send_cmd(input fire_cmd_pkg::cmd_type_t t, input fire_cmd_pkg::chan_mask_t m);
		cmd_valid      = 1'b1;
		cmd.cmd_type   = t;
		cmd.param      = {12'h000, m};
		@(negedge clk);
		cmd_valid      = 1'b0;
		cmd            = '0;
	endtask

	task automatic run_row(input int i);
		fire_cmd_pkg::chan_mask_t cleared;
		int                       waited;
		int                       fired;
		@(negedge clk);
		cur_row_name = row_name[i];
		cur_ack_low  = !rows[i].ack_never;
		pwr_ack      = rows[i].ack_never;                         // high means no ack
		exp_order.delete();
		if (rows[i].cmd_type == CMD_FIRE) begin
			for (int b = 0; b < fire_drive_pkg::NUM_CHANNELS; b++) begin
				if (rows[i].mask[b]) begin
					exp_order.push_back(fire_drive_pkg::chan_idx_t'(b));
				end
			end
		end
		fire_base = fire_total;
		cleared   = (rows[i].cmd_type == CMD_FIRE) ? (model_status & ~rows[i].mask)
			: model_status;
		send_cmd(rows[i].cmd_type, rows[i].mask);
		check_mask(cur_row_name, cleared, status);                // masked bits cleared
		if (rows[i].inject) begin
			waited = 0;
			while (!drive_main.pwr_on && (waited < ROW_BOUND)) begin
				@(negedge clk);
				waited++;
			end
			if (!drive_main.pwr_on) begin
				report_failure("no firing started before the mid-firing command");
			end
			send_cmd(CMD_FIRE, 20'h0F000);                        // must be ignored
		end
		waited = 0;
		while ((status !== rows[i].exp_status) && (waited < ROW_BOUND)) begin
			@(negedge clk);
			waited++;
		end
		check_mask(cur_row_name, rows[i].exp_status, status);
		waited = 0;
		while (drive_main.pwr_on && (waited < DWELL_CYCLES)) begin
			@(negedge clk);
			waited++;
		end
		repeat (GUARD_CYCLES + 4) @(negedge clk);                 // room for a stray firing
		fired = fire_total - fire_base;
		if (fired != exp_order.size()) begin
			report_failure($sformatf("row %s fired %0d channels where %0d were due",
				cur_row_name, fired, exp_order.size()));
		end
		model_err    = model_err + rows[i].exp_err_inc;
		model_status = rows[i].exp_status;
		check_err(cur_row_name, model_err, err_count);
	endtask

	// --------------------
	// firing monitor
	// --------------------
	always @(posedge clk) begin
		if (mon_on) begin
			if (drive_main.pwr_on && !pwr_was_on) begin
				if ((fire_total - fire_base) >= exp_order.size()) begin
					report_failure($sformatf("row %s fired a channel that was not pending",
						cur_row_name));
				end else begin
					seen_chan = drive_main.low_en_n ? {3'b100, drive_main.high_code}
						: {1'b0, drive_main.low_code};
					cur_exp   = exp_order[fire_total - fire_base];
					check_chan(cur_row_name, cur_exp, seen_chan);
					fire_total++;
				end
			end
			if (drive_main.pwr_on) begin
				check_drive(cur_row_name, fire_drive_exp(cur_exp, cur_ack_low), drive_main);
				check_drive(cur_row_name, fire_drive_exp(cur_exp, cur_ack_low), drive_backup);
			end else begin
				check_drive(cur_row_name, IDLE_EXP, drive_main);
				check_drive(cur_row_name, IDLE_EXP, drive_backup);
			end
			pwr_was_on = drive_main.pwr_on;
		end
	end

	// run length limit
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > RUN_LIMIT) begin
			report_failure($sformatf("timeout after %0d cycles with rows unfinished", RUN_LIMIT));
		end
	end

	initial begin
		fill_table();
		repeat (10) @(negedge clk);                               // reset for 10 cycles
		rst_n = 1'b1;
		check_drive("reset", IDLE_EXP, drive_main);
		check_drive("reset", IDLE_EXP, drive_backup);
		check_mask("reset", 20'h00000, status);
		check_err("reset", 8'd0, err_count);
		mon_on = 1'b1;
		for (int i = 0; i < NUM_ROWS; i++) begin
			run_row(i);
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

// File: testbench/ignition_checker.sv
// decoder drive checker: concurrent assertions on the firing bus drive word
`timescale 1ns/10ps

module ignition_checker (
	input logic                           clk,
	input logic                           rst_n,
	input logic                           firing,     // sequencer state
	input fire_drive_pkg::decoder_drive_t drive       // registered drive word
);

	// --------------------
	// bank exclusion
	// --------------------
	no_dual_enable: assert property (@(posedge clk) disable iff (!rst_n)
		!(!drive.low_en_n && !drive.high_en_n))       // one decoder at a time
		else $error("both decoder enables low in the same cycle");

	// latch strobe only on a powered bus
	strobe_needs_power: assert property (@(posedge clk) disable iff (!rst_n)
		drive.low_strobe |-> drive.pwr_on)
		else $error("latch strobe high while bus power is off");

	// --------------------
	// idle drive
	// --------------------
	// drive is registered, so it shows idle one cycle after firing drops
	idle_when_not_firing: assert property (@(posedge clk) disable iff (!rst_n)
		!firing |=> (drive == fire_drive_pkg::DRIVE_IDLE))
		else $error("drive word not idle after firing ended");

endmodule

bind decoder_drive ignition_checker u_checker (
	.clk    (clk),
	.rst_n  (rst_n),
	.firing (firing),
	.drive  (drive)
);

// File: logic/ignition_ctrl_top.sv
// ignition controller top: twenty channel firing sequencer with duplicated decoder drive
`timescale 1ns/10ps

module ignition_ctrl_top #(
	parameter int unsigned GUARD_CYCLES       = 50000,   // idle gap before a firing
	parameter int unsigned DWELL_CYCLES       = 400000,  // firing hold
	parameter int unsigned ACK_TIMEOUT_CYCLES = 5000     // below DWELL_CYCLES
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           cmd_valid,
	input  fire_cmd_pkg::fire_cmd_t        cmd,
	input  logic                           pwr_ack,       // active low
	output fire_drive_pkg::decoder_drive_t drive_main,
	output fire_drive_pkg::decoder_drive_t drive_backup,
	output fire_cmd_pkg::chan_mask_t       status,
	output fire_cmd_pkg::err_count_t       err_count
);

	logic                           cmd_take;
	logic                           firing;
	logic                           fire_done;
	logic                           pending_any;
	logic                           guard_done;
	logic                           dwell_done;
	fire_drive_pkg::chan_idx_t      cur_chan;
	fire_drive_pkg::decoder_drive_t drive;

	// --------------------
	// control
	// --------------------
	fire_sequencer u_sequencer (
		.clk         (clk),
		.rst_n       (rst_n),
		.cmd_valid   (cmd_valid),
		.cmd_type    (cmd.cmd_type),
		.pending_any (pending_any),
		.guard_done  (guard_done),
		.dwell_done  (dwell_done),
		.cmd_take    (cmd_take),
		.firing      (firing),
		.fire_done   (fire_done)
	);

	fire_timer #(
		.GUARD_CYCLES (GUARD_CYCLES),
		.DWELL_CYCLES (DWELL_CYCLES)
	) u_timer (
		.clk        (clk),
		.rst_n      (rst_n),
		.firing     (firing),
		.guard_done (guard_done),
		.dwell_done (dwell_done)
	);

	// --------------------
	// datapath
	// --------------------
	channel_ledger u_ledger (
		.clk         (clk),
		.rst_n       (rst_n),
		.cmd_take    (cmd_take),
		.cmd_mask    (cmd.param[fire_drive_pkg::NUM_CHANNELS-1:0]),  // upper bits unused
		.fire_done   (fire_done),
		.pending_any (pending_any),
		.cur_chan    (cur_chan),
		.status      (status)
	);

	decoder_drive #(
		.ACK_TIMEOUT_CYCLES (ACK_TIMEOUT_CYCLES)
	) u_drive (
		.clk       (clk),
		.rst_n     (rst_n),
		.firing    (firing),
		.cur_chan  (cur_chan),
		.pwr_ack   (pwr_ack),
		.drive     (drive),
		.err_count (err_count)
	);

	// same drive word on both harnesses
	assign drive_main   = drive;
	assign drive_backup = drive;

endmodule

// File: logic/decoder_drive.sv
// decoder drive: registered decoder and power lines, power acknowledge timeout and error count
`timescale 1ns/10ps

module decoder_drive #(
	parameter int unsigned ACK_TIMEOUT_CYCLES = 5000
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           firing,
	input  fire_drive_pkg::chan_idx_t      cur_chan,
	input  logic                           pwr_ack,    // low when bus power is up
	output fire_drive_pkg::decoder_drive_t drive,
	output fire_cmd_pkg::err_count_t       err_count
);

	localparam int unsigned LOW_W  = $bits(fire_drive_pkg::low_code_t);
	localparam int unsigned HIGH_W = $bits(fire_drive_pkg::high_code_t);
	localparam int unsigned WAIT_W = $clog2(ACK_TIMEOUT_CYCLES + 1);

	typedef logic [WAIT_W-1:0] ack_wait_t;

	localparam ack_wait_t ACK_LIMIT = ack_wait_t'(ACK_TIMEOUT_CYCLES);
	localparam fire_drive_pkg::chan_idx_t LOW_BASE =
		fire_drive_pkg::chan_idx_t'(fire_drive_pkg::LOW_BANK_SIZE);

	fire_drive_pkg::decoder_drive_t drive_nxt;
	fire_drive_pkg::chan_idx_t      high_idx;
	logic                           low_bank;
	logic                           ack_missing;
	ack_wait_t                      ack_wait;

	// --------------------
	// bank select
	// --------------------
	assign low_bank = (cur_chan < LOW_BASE);
	assign high_idx = cur_chan - LOW_BASE;            // offset inside the small decoder

	always_comb begin
		drive_nxt = fire_drive_pkg::DRIVE_IDLE;
		if (firing) begin
			drive_nxt.pwr_on = 1'b1;                  // request bus power
			if (low_bank) begin
				drive_nxt.low_code   = cur_chan[LOW_W-1:0];
				drive_nxt.low_en_n   = 1'b0;          // decoder on for the dwell
				drive_nxt.low_strobe = !pwr_ack;      // latch only with power up
			end else begin
				drive_nxt.high_code = high_idx[HIGH_W-1:0];
				drive_nxt.high_en_n = pwr_ack;        // enable tracks the ack
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			drive <= fire_drive_pkg::DRIVE_IDLE;
		end else begin
			drive <= drive_nxt;                       // one cycle behind firing
		end
	end

	// --------------------
	// ack timeout
	// --------------------
	assign ack_missing = firing && pwr_ack;

	// counter parks at the limit, so one error per firing at most
	always_ff @(posedge clk) begin
		if (!rst_n || !firing) begin
			ack_wait <= '0;
		end else if (ack_missing && (ack_wait != ACK_LIMIT)) begin
			ack_wait <= ack_wait + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			err_count <= '0;
		end else if (ack_missing && (ack_wait == ACK_LIMIT - 1'b1)) begin
			err_count <= err_count + 1'b1;            // wraps
		end
	end

endmodule

// File: logic/channel_ledger.sv
// channel ledger: pending and fired status per channel, lowest pending channel select
`timescale 1ns/10ps

module channel_ledger (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     cmd_take,     // load a new mask
	input  fire_cmd_pkg::chan_mask_t cmd_mask,
	input  logic                     fire_done,    // retire cur_chan
	output logic                     pending_any,
	output fire_drive_pkg::chan_idx_t cur_chan,    // lowest pending channel
	output fire_cmd_pkg::chan_mask_t status        // bit set once fired
);

	fire_cmd_pkg::chan_mask_t pending;
	fire_cmd_pkg::chan_mask_t retire_bit;

	// --------------------
	// priority pick
	// --------------------
	// scan downwards so the lowest set bit is the one left standing
	always_comb begin
		cur_chan = '0;
		for (int i = fire_drive_pkg::NUM_CHANNELS - 1; i >= 0; i--) begin
			if (pending[i]) begin
				cur_chan = fire_drive_pkg::chan_idx_t'(i);
			end
		end
	end

	assign pending_any = |pending;

	// one-hot of the channel being retired
	assign retire_bit = fire_cmd_pkg::chan_mask_t'(1) << cur_chan;

	// --------------------
	// registers
	// --------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pending <= '0;
			status  <= '0;
		end else if (cmd_take) begin
			pending <= cmd_mask;                // replaces any old mask
			status  <= status & ~cmd_mask;      // masked channels start unfired
		end else if (fire_done) begin
			pending <= pending & ~retire_bit;   // done with this one
			status  <= status | retire_bit;     // report it fired
		end
	end

endmodule

// File: logic/fire_timer.sv
// firing timer: guard interval between firings and dwell length of each firing
`timescale 1ns/10ps

module fire_timer #(
	parameter int unsigned GUARD_CYCLES = 50000,
	parameter int unsigned DWELL_CYCLES = 400000
) (
	input  logic clk,
	input  logic rst_n,
	input  logic firing,           // from the sequencer
	output logic guard_done,       // idle long enough
	output logic dwell_done        // last cycle of the dwell
);

	localparam int unsigned GUARD_W = $clog2(GUARD_CYCLES + 1);
	localparam int unsigned DWELL_W = $clog2(DWELL_CYCLES + 1);

	typedef logic [GUARD_W-1:0] guard_cnt_t;
	typedef logic [DWELL_W-1:0] dwell_cnt_t;

	localparam guard_cnt_t GUARD_LAST = guard_cnt_t'(GUARD_CYCLES);
	localparam dwell_cnt_t DWELL_LAST = dwell_cnt_t'(DWELL_CYCLES - 1);

	guard_cnt_t guard_cnt;
	dwell_cnt_t dwell_cnt;

	// --------------------
	// guard counter
	// --------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			guard_cnt <= '0;
		end else if (firing) begin
			guard_cnt <= '0;                    // restart for the next gap
		end else if (guard_cnt != GUARD_LAST) begin
			guard_cnt <= guard_cnt + 1'b1;      // saturate at the limit
		end
	end

	// dwell counter, zero whenever not firing
	always_ff @(posedge clk) begin
		if (!rst_n || !firing) begin
			dwell_cnt <= '0;
		end else begin
			dwell_cnt <= dwell_cnt + 1'b1;
		end
	end

	assign guard_done = (guard_cnt == GUARD_LAST);
	assign dwell_done = firing && (dwell_cnt == DWELL_LAST);

endmodule

// File: logic/fire_sequencer.sv
// firing sequencer FSM: takes fire commands in idle and frames each channel firing
`timescale 1ns/10ps

module fire_sequencer (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    cmd_valid,      // one-cycle command strobe
	input  fire_cmd_pkg::cmd_type_t cmd_type,
	input  logic                    pending_any,    // some channel still to fire
	input  logic                    guard_done,     // idle gap has elapsed
	input  logic                    dwell_done,     // last firing cycle
	output logic                    cmd_take,       // fire command accepted
	output logic                    firing,         // high for the whole dwell
	output logic                    fire_done       // end of dwell strobe
);

	typedef enum logic {
		ST_IDLE,
		ST_FIRING
	} seq_state_t;

	seq_state_t state;
	seq_state_t state_nxt;
	logic       is_fire_cmd;
	logic       start_fire;

	// --------------------
	// command acceptance
	// --------------------
	assign is_fire_cmd = (cmd_type == fire_cmd_pkg::CMD_FIRE);  // other codes dropped
	assign cmd_take    = cmd_valid && is_fire_cmd && (state == ST_IDLE);

	// a new mask being loaded this cycle wins over starting a firing
	assign start_fire = guard_done && pending_any && !cmd_take;

	// --------------------
	// state machine
	// --------------------
	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (start_fire) begin
					state_nxt = ST_FIRING;            // next pending channel
				end
			end
			ST_FIRING: begin
				if (dwell_done) begin
					state_nxt = ST_IDLE;              // back to guard wait
				end
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// --------------------
	// outputs
	// --------------------
	assign firing    = (state == ST_FIRING);
	assign fire_done = firing && dwell_done;      // retire strobe to the ledger

endmodule

// File: logic/fire_drive_pkg.sv
// decoder drive package: channel index, decoder bank split and firing bus drive word
package fire_drive_pkg;

	// --------------------
	// channel map
	// --------------------
	localparam int NUM_CHANNELS   = $bits(fire_cmd_pkg::chan_mask_t);  // one per mask bit
	localparam int LOW_BANK_SIZE  = 16;                                // 4-to-16 latch decoder
	localparam int HIGH_BANK_SIZE = NUM_CHANNELS - LOW_BANK_SIZE;      // 2-to-4 decoder

	typedef logic [$clog2(NUM_CHANNELS)-1:0]   chan_idx_t;   // 0..19
	typedef logic [$clog2(LOW_BANK_SIZE)-1:0]  low_code_t;   // latch decoder data
	typedef logic [$clog2(HIGH_BANK_SIZE)-1:0] high_code_t;  // small decoder select

	// --------------------
	// drive word
	// --------------------
	// one copy of this goes to each of the primary and backup ports
	typedef struct packed {
		low_code_t  low_code;                 // latch decoder data code
		logic       low_strobe;               // latch strobe, high active
		logic       low_en_n;                 // latch decoder enable
		high_code_t high_code;                // 2-to-4 select
		logic       high_en_n;                // 2-to-4 enable
		logic       pwr_on;                   // firing bus power request
	} decoder_drive_t;

	// nothing selected, bus unpowered
	localparam decoder_drive_t DRIVE_IDLE = '{
		low_code:   '0,
		low_strobe: 1'b0,
		low_en_n:   1'b1,
		high_code:  '0,
		high_en_n:  1'b1,
		pwr_on:     1'b0
	};

endpackage

// File: logic/fire_cmd_pkg.sv
// fire command package: command word layout, command codes and channel mask types
package fire_cmd_pkg;

	// --------------------
	// command word
	// --------------------
	typedef logic [7:0]  cmd_type_t;                  // command code, one word
	typedef logic [31:0] cmd_param_t;                 // raw parameter field

	localparam cmd_type_t CMD_FIRE = 8'h05;           // fire the masked channels

	// one bit per initiation channel, bit n = channel n
	typedef logic [19:0] chan_mask_t;

	// command as it arrives on the port
	typedef struct packed {
		cmd_type_t  cmd_type;                         // what to do
		cmd_param_t param;                            // low bits carry the mask
	} fire_cmd_t;

	// --------------------
	// error reporting
	// --------------------
	typedef logic [7:0] err_count_t;                  // wraps at 255

endpackage
